//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := cdc_fifo_tb
FILELIST := tb.f
PASS_MSG := Finished with no errors

OBJ_DIR  := obj_dir
SIM_BIN  := $(OBJ_DIR)/V$(TOP)
SRCS     := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS     := $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- include/cdc_fifo_macros.svh
`ifndef CDC_FIFO_MACROS_SVH
`define CDC_FIFO_MACROS_SVH

// every pointer register in both clock domains clears to this value
// the synchronizers clear to the same value as the pointers they carry
// so that no false full or empty shows up while the domains leave reset
// an all zero binary pointer is also all zero in Gray code
// which keeps both pointer copies in step after reset
`define CDC_FIFO_PTR_RST '0

`endif

//--- src/cdc_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo (
  input  logic                w_clk,
  input  logic                w_rst_n,
  input  logic                w_inc,
  input  cdc_fifo_pkg::data_t w_data,
  output logic                w_full,
  output logic                w_almost_full,
  input  logic                r_clk,
  input  logic                r_rst_n,
  input  logic                r_inc,
  output cdc_fifo_pkg::data_t r_data,
  output logic                r_empty
);
  import cdc_fifo_pkg::*;

  // Gray pointers in their home domain and after crossing
  ptr_t  w_ptr;
  ptr_t  r_ptr;
  ptr_t  w_q2_rptr;
  ptr_t  r_q2_wptr;
  addr_t w_addr;
  addr_t r_addr;
  logic  w_en;

  // write side owns the write pointer and the full flags
  cdc_fifo_wptr_full u_wptr (
    .w_clk         (w_clk),
    .w_rst_n       (w_rst_n),
    .w_inc         (w_inc),
    .w_q2_rptr     (w_q2_rptr),
    .w_full        (w_full),
    .w_almost_full (w_almost_full),
    .w_ptr         (w_ptr),
    .w_addr        (w_addr),
    .w_en          (w_en)
  );

  // read side owns the read pointer and the empty flag
  cdc_fifo_rptr_empty u_rptr (
    .r_clk     (r_clk),
    .r_rst_n   (r_rst_n),
    .r_inc     (r_inc),
    .r_q2_wptr (r_q2_wptr),
    .r_empty   (r_empty),
    .r_ptr     (r_ptr),
    .r_addr    (r_addr)
  );

  // write pointer into the read domain, clocked by r_clk
  cdc_fifo_sync2 u_sync_w2r (
    .clk   (r_clk),
    .rst_n (r_rst_n),
    .d     (w_ptr),
    .q     (r_q2_wptr)
  );

  // read pointer into the write domain, clocked by w_clk
  cdc_fifo_sync2 u_sync_r2w (
    .clk   (w_clk),
    .rst_n (w_rst_n),
    .d     (r_ptr),
    .q     (w_q2_rptr)
  );

  cdc_fifo_mem u_mem (
    .w_clk  (w_clk),
    .w_en   (w_en),
    .w_addr (w_addr),
    .w_data (w_data),
    .r_addr (r_addr),
    .r_data (r_data)
  );

endmodule

`default_nettype wire

//--- src/cdc_fifo_mem.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_mem (
  input  logic                w_clk,
  input  logic                w_en,
  input  cdc_fifo_pkg::addr_t w_addr,
  input  cdc_fifo_pkg::data_t w_data,
  input  cdc_fifo_pkg::addr_t r_addr,
  output cdc_fifo_pkg::data_t r_data
);
  import cdc_fifo_pkg::*;

  // one register per slot, the pointer logic keeps reads and writes apart
  data_t mem [fifo_depth];

  // a word lands at the same w_clk edge that accepts it
  always_ff @(posedge w_clk) begin
    if (w_en) begin
      mem[w_addr] <= w_data;
    end
  end

  // read side is combinational, so the head word falls through to r_data
  // the slot under r_addr is stable by the time r_empty has cleared
  assign r_data = mem[r_addr];

endmodule

`default_nettype wire

//--- src/cdc_fifo_pkg.sv
`default_nettype none

package cdc_fifo_pkg;

  // number of address bits, the storage holds 2**addr_size words
  localparam int addr_size = 4;
  localparam int fifo_depth = 1 << addr_size;
  localparam int data_width = 8;
  // almost-full rises once the free slots drop to this count or below
  localparam int almost_full_buf = 2;

  // pointers carry one extra bit so a full FIFO can be told apart from an empty one
  typedef logic [addr_size:0] ptr_t;
  typedef logic [addr_size-1:0] addr_t;
  typedef logic [data_width-1:0] data_t;

  // neighbouring binary values differ in exactly one bit once Gray coded
  function automatic ptr_t bin_to_gray(input ptr_t bin);
    return (bin >> 1) ^ bin;
  endfunction

  // each binary bit is the xor of all Gray bits at and above it
  function automatic ptr_t gray_to_bin(input ptr_t gray);
    ptr_t bin;
    bin[addr_size] = gray[addr_size];
    for (int i = addr_size - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

`default_nettype wire

//--- src/cdc_fifo_rptr_empty.sv
`timescale 1ns/1ps
`default_nettype none

`include "cdc_fifo_macros.svh"

module cdc_fifo_rptr_empty (
  input  logic                r_clk,
  input  logic                r_rst_n,
  input  logic                r_inc,
  input  cdc_fifo_pkg::ptr_t  r_q2_wptr,
  output logic                r_empty,
  output cdc_fifo_pkg::ptr_t  r_ptr,
  output cdc_fifo_pkg::addr_t r_addr
);
  import cdc_fifo_pkg::*;

  // binary copy of the read pointer, r_ptr is its Gray twin
  ptr_t r_bin;
  ptr_t r_bin_next;
  ptr_t r_gray_next;
  logic r_pop;
  logic r_empty_val;

  // a pop while empty is ignored and leaves the pointers alone
  assign r_pop = r_inc & ~r_empty;

  // the head word sits at this address, the memory reads it without a clock
  assign r_addr = r_bin[addr_size-1:0];

  assign r_bin_next = r_bin + {{addr_size{1'b0}}, r_pop};
  assign r_gray_next = bin_to_gray(r_bin_next);

  always_ff @(posedge r_clk) begin
    if (!r_rst_n) begin
      r_bin <= `CDC_FIFO_PTR_RST;
      r_ptr <= `CDC_FIFO_PTR_RST;
    end else begin
      r_bin <= r_bin_next;
      r_ptr <= r_gray_next;
    end
  end

  // empty when the reader catches up with the writer, same lap and same slot
  // the next pointer lets empty rise at the edge that pops the last word
  assign r_empty_val = (r_gray_next == r_q2_wptr);

  // the write pointer arrives late, so empty can only linger, never clear early
  always_ff @(posedge r_clk) begin
    if (!r_rst_n) begin
      r_empty <= 1'b1;
    end else begin
      r_empty <= r_empty_val;
    end
  end

endmodule

`default_nettype wire

//--- src/cdc_fifo_sync2.sv
`timescale 1ns/1ps
`default_nettype none

`include "cdc_fifo_macros.svh"

module cdc_fifo_sync2 (
  input  logic               clk,
  input  logic               rst_n,
  input  cdc_fifo_pkg::ptr_t d,
  output cdc_fifo_pkg::ptr_t q
);
  import cdc_fifo_pkg::*;

  // first stage may go metastable, the second stage gives it a cycle to settle
  ptr_t q1;

  // d is Gray coded, so at most one bit is in motion when it is sampled
  // a late sample therefore shows the old or the new pointer, never a mix
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      q1 <= `CDC_FIFO_PTR_RST;
      q  <= `CDC_FIFO_PTR_RST;
    end else begin
      q1 <= d;
      q  <= q1;
    end
  end

endmodule

`default_nettype wire

//--- src/cdc_fifo_wptr_full.sv
`timescale 1ns/1ps
`default_nettype none

`include "cdc_fifo_macros.svh"

module cdc_fifo_wptr_full (
  input  logic                w_clk,
  input  logic                w_rst_n,
  input  logic                w_inc,
  input  cdc_fifo_pkg::ptr_t  w_q2_rptr,
  output logic                w_full,
  output logic                w_almost_full,
  output cdc_fifo_pkg::ptr_t  w_ptr,
  output cdc_fifo_pkg::addr_t w_addr,
  output logic                w_en
);
  import cdc_fifo_pkg::*;

  // binary copy of the write pointer, w_ptr is its Gray twin
  ptr_t w_bin;
  ptr_t w_bin_next;
  ptr_t w_gray_next;
  logic w_full_val;
  // read pointer seen from the write domain, in binary
  ptr_t w_r_bin;
  ptr_t w_slots_used;
  logic w_almost_full_val;

  // a write is only taken while there is room, otherwise it is dropped
  assign w_en = w_inc & ~w_full;

  // the storage is addressed with the binary pointer minus its wrap bit
  assign w_addr = w_bin[addr_size-1:0];

  assign w_bin_next = w_bin + {{addr_size{1'b0}}, w_en};
  assign w_gray_next = bin_to_gray(w_bin_next);

  always_ff @(posedge w_clk) begin
    if (!w_rst_n) begin
      w_bin <= `CDC_FIFO_PTR_RST;
      w_ptr <= `CDC_FIFO_PTR_RST;
    end else begin
      w_bin <= w_bin_next;
      w_ptr <= w_gray_next;
    end
  end

  // full means the writer is one lap ahead of the reader
  // in Gray code that is the read pointer with its two top bits flipped
  // using the next pointer makes full rise at the edge that takes the last slot
  assign w_full_val = (w_gray_next == {~w_q2_rptr[addr_size:addr_size-1],
                                       w_q2_rptr[addr_size-2:0]});

  // Gray codes cannot be ordered, so the occupancy is taken in binary
  // the subtraction wraps correctly thanks to the extra pointer bit
  assign w_r_bin = gray_to_bin(w_q2_rptr);
  assign w_slots_used = w_bin - w_r_bin;
  assign w_almost_full_val = (w_slots_used >= ptr_t'(fifo_depth - almost_full_buf));

  // the read pointer is stale by the synchronizer delay
  // so both flags can only stay set too long, never clear too early
  always_ff @(posedge w_clk) begin
    if (!w_rst_n) begin
      w_full        <= 1'b0;
      w_almost_full <= 1'b0;
    end else begin
      w_full        <= w_full_val;
      w_almost_full <= w_almost_full_val;
    end
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
src/cdc_fifo_pkg.sv
src/cdc_fifo_sync2.sv
src/cdc_fifo_wptr_full.sv
src/cdc_fifo_rptr_empty.sv
src/cdc_fifo_mem.sv
src/cdc_fifo.sv
test/cdc_fifo_assert.sv
test/cdc_fifo_tb.sv

//--- test/cdc_fifo_assert.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_assert (
  input logic w_clk,
  input logic w_rst_n,
  input logic r_clk,
  input logic r_rst_n,
  input logic w_full,
  input logic w_almost_full,
  input logic r_empty
);

  // once both domains are out of reset a full FIFO can never look empty as well
  full_not_empty: assert property (
    @(posedge w_clk) disable iff (!w_rst_n || !r_rst_n) !(w_full && r_empty)
  ) else $error("w_full and r_empty are high at the same time");

  // full is the top end of the almost-full range
  full_implies_almost_full: assert property (
    @(posedge w_clk) disable iff (!w_rst_n) w_full |-> w_almost_full
  ) else $error("w_full is high while w_almost_full is low");

  // first write clock edge out of reset still shows the cleared flags
  write_flags_after_reset: assert property (
    @(posedge w_clk) $rose(w_rst_n) |-> (!w_full && !w_almost_full)
  ) else $error("write side flags are not clear right after reset");

  // the read side starts out empty
  read_empty_after_reset: assert property (
    @(posedge r_clk) $rose(r_rst_n) |-> r_empty
  ) else $error("r_empty is low right after reset");

endmodule

`default_nettype wire

//--- test/cdc_fifo_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_tb;
  import cdc_fifo_pkg::*;

  typedef enum int {op_write, op_read, op_stream} op_e;

  // one phase of traffic and the flags it should leave behind once settled
  typedef struct {
    string name;
    op_e   op;
    int    count;
    int    gap_mask;
    int    exp_level;
    logic  exp_full;
    logic  exp_almost_full;
    logic  exp_empty;
  } row_t;

  logic  w_clk;
  logic  w_rst_n;
  logic  w_inc;
  data_t w_data;
  logic  w_full;
  logic  w_almost_full;
  logic  r_clk;
  logic  r_rst_n;
  logic  r_inc;
  data_t r_data;
  logic  r_empty;

  row_t        rows[$];
  // model of the words the FIFO holds with the oldest at the front
  data_t       model[$];
  logic [31:0] lcg_state;
  int          value_errors;
  int          other_errors;
  int          timeout_limit;

  cdc_fifo dut0 (
    .w_clk         (w_clk),
    .w_rst_n       (w_rst_n),
    .w_inc         (w_inc),
    .w_data        (w_data),
    .w_full        (w_full),
    .w_almost_full (w_almost_full),
    .r_clk         (r_clk),
    .r_rst_n       (r_rst_n),
    .r_inc         (r_inc),
    .r_data        (r_data),
    .r_empty       (r_empty)
  );

  bind cdc_fifo cdc_fifo_assert u_assert (
    .w_clk         (w_clk),
    .w_rst_n       (w_rst_n),
    .r_clk         (r_clk),
    .r_rst_n       (r_rst_n),
    .w_full        (w_full),
    .w_almost_full (w_almost_full),
    .r_empty       (r_empty)
  );

  // 20 ns write clock and 34 ns read clock, so the edges drift against each other
  initial begin
    w_clk = 1'b0;
    forever #10 w_clk = ~w_clk;
  end

  initial begin
    r_clk = 1'b0;
    forever #17 r_clk = ~r_clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // upper bits of the LCG are used since its low bits repeat quickly
  function automatic int rand_gap(input int mask);
    logic [31:0] r;
    r = lcg_next();
    return int'(r[23:16]) & mask;
  endfunction

  task automatic add_row(input string name, input op_e op, input int count, input int mask,
                         input int level, input logic full, input logic af, input logic empty);
    row_t row;
    row.name = name;
    row.op = op;
    row.count = count;
    row.gap_mask = mask;
    row.exp_level = level;
    row.exp_full = full;
    row.exp_almost_full = af;
    row.exp_empty = empty;
    rows.push_back(row);
    timeout_limit = timeout_limit + count * 8;
  endtask

  task automatic load_table();
    // almost-full is probed at 13, 14 and 15 words and full at 16
    add_row("fill13", op_write, 13, 0, 13, 1'b0, 1'b0, 1'b0);
    add_row("fill14", op_write, 1, 0, 14, 1'b0, 1'b1, 1'b0);
    add_row("fill15", op_write, 1, 0, 15, 1'b0, 1'b1, 1'b0);
    add_row("fill16", op_write, 1, 0, 16, 1'b1, 1'b1, 1'b0);
    // writes offered while full must leave no trace
    add_row("overflow", op_write, 4, 0, 16, 1'b1, 1'b1, 1'b0);
    add_row("drain", op_read, 16, 1, 0, 1'b0, 1'b0, 1'b1);
    add_row("underflow", op_read, 3, 0, 0, 1'b0, 1'b0, 1'b1);
    add_row("refill", op_write, 1, 0, 1, 1'b0, 1'b0, 1'b0);
    add_row("read_one", op_read, 1, 0, 0, 1'b0, 1'b0, 1'b1);
    add_row("stream", op_stream, 200, 3, 0, 1'b0, 1'b0, 1'b1);
    timeout_limit = timeout_limit + 200;
  endtask

  task automatic report_mismatch(input string test, input string what, input int exp,
                                 input int act);
    $display("[FAIL] %s %s: expected %0h, actual %0h", test, what, exp, act);
    value_errors++;
  endtask

  // r_data is first-word fall-through, so the head word is visible before the pop
  task automatic check_pop(input string name);
    data_t exp;
    if (model.size() == 0) begin
      $display("%s: the DUT offered a word while the model holds none", name);
      other_errors++;
    end else begin
      exp = model.pop_front();
      if (r_data !== exp) begin
        report_mismatch(name, "r_data", int'(exp), int'(r_data));
      end
    end
  endtask

  // with retry set a dropped word is held and offered again, as a producer must
  task automatic write_words(input int count, input int mask, input logic retry);
    logic [31:0] r;
    logic done;
    for (int i = 0; i < count; i++) begin
      repeat (rand_gap(mask)) begin
        @(negedge w_clk);
        w_inc = 1'b0;
      end
      r = lcg_next();
      done = 1'b0;
      while (!done) begin
        @(negedge w_clk);
        w_data = r[31:24];
        w_inc = 1'b1;
        // the flag is stable here, so it decides the next rising edge
        if (!w_full) begin
          model.push_back(r[31:24]);
        end
        done = !w_full || !retry;
      end
    end
    @(negedge w_clk);
    w_inc = 1'b0;
  endtask

  // streaming counts only real pops while the other phases count every read attempt
  task automatic read_words(input string name, input int count, input int mask,
                            input logic count_pops);
    int done;
    done = 0;
    while (done < count) begin
      repeat (rand_gap(mask)) begin
        @(negedge r_clk);
        r_inc = 1'b0;
      end
      @(negedge r_clk);
      r_inc = 1'b1;
      if (!r_empty) begin
        check_pop(name);
      end
      if (!r_empty || !count_pops) begin
        done++;
      end
    end
    @(negedge r_clk);
    r_inc = 1'b0;
  endtask

  // four idle cycles on each side let every pointer cross and the flags settle
  task automatic settle_and_check(input row_t row);
    repeat (4) @(posedge r_clk);
    repeat (4) @(posedge w_clk);
    @(negedge w_clk);
    if (w_full !== row.exp_full) begin
      report_mismatch(row.name, "w_full", int'(row.exp_full), int'(w_full));
    end
    if (w_almost_full !== row.exp_almost_full) begin
      report_mismatch(row.name, "w_almost_full", int'(row.exp_almost_full),
                      int'(w_almost_full));
    end
    @(negedge r_clk);
    if (r_empty !== row.exp_empty) begin
      report_mismatch(row.name, "r_empty", int'(row.exp_empty), int'(r_empty));
    end
    if (model.size() != row.exp_level) begin
      report_mismatch(row.name, "occupancy", row.exp_level, model.size());
    end
  endtask

  task automatic run_row(input row_t row);
    case (row.op)
      op_write: write_words(row.count, row.gap_mask, 1'b0);
      op_read: read_words(row.name, row.count, row.gap_mask, 1'b0);
      default: begin
        fork
          write_words(row.count, row.gap_mask, 1'b1);
          read_words(row.name, row.count, row.gap_mask, 1'b1);
        join
      end
    endcase
    settle_and_check(row);
  endtask

  initial begin
    w_rst_n = 1'b0;
    r_rst_n = 1'b0;
    w_inc = 1'b0;
    w_data = '0;
    r_inc = 1'b0;
    lcg_state = 32'ha7fe3db4;
    value_errors = 0;
    other_errors = 0;
    timeout_limit = 0;
    load_table();
    // each reset is held for four cycles of its own clock
    fork
      begin
        repeat (4) @(negedge w_clk);
        w_rst_n = 1'b1;
      end
      begin
        repeat (4) @(negedge r_clk);
        r_rst_n = 1'b1;
      end
    join
    @(negedge w_clk);
    if (w_full !== 1'b0) begin
      report_mismatch("reset", "w_full", 0, int'(w_full));
    end
    if (w_almost_full !== 1'b0) begin
      report_mismatch("reset", "w_almost_full", 0, int'(w_almost_full));
    end
    @(negedge r_clk);
    if (r_empty !== 1'b1) begin
      report_mismatch("reset", "r_empty", 1, int'(r_empty));
    end
    foreach (rows[i]) begin
      run_row(rows[i]);
    end
    $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // the limit grows with the table so a stuck handshake ends the run
  initial begin
    int cycles;
    cycles = 0;
    wait (timeout_limit > 0);
    while (cycles < timeout_limit) begin
      @(posedge w_clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d write clock cycles", timeout_limit);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire
